/* ifu_aln_pkg.sv */
// Shared types for the fetch aligner.
// PCs are halfword addresses, so address bit 0 is never carried.
// A fetch packet is fixed at two halfwords, low halfword first.

package ifu_aln_pkg;

   // ******************************
   // packet geometry
   // ******************************

   parameter int HW_PER_FETCH = 2;            // halfwords per fetch packet

   // one instruction halfword
   typedef logic [15:0] hw_t;

   // fetch packet data, halfword 0 in the low bits
   typedef logic [HW_PER_FETCH*$bits(hw_t)-1:0] fetch_word_t;

   // ******************************
   // addresses and flags
   // ******************************

   // pc bits 31:1
   typedef logic [31:1] pc_t;

   // one bit per halfword of a packet, for valids and faults
   // valids are right justified: 01 or 11
   typedef logic [HW_PER_FETCH-1:0] hw_mask_t;

   // ******************************
   // flow control
   // ******************************

   // credits handed back to fetch in one cycle, 0..2
   typedef logic [1:0] credit_t;

endpackage

/* fetch_buf_entry.sv */
// One fetch buffer entry of the aligner ring.
// The writer only targets an empty entry, so a write and a release
// never hit the same entry in one cycle. Flush wins over everything.

`timescale 1ns/1ps

module fetch_buf_entry (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     wr_en,
   input  logic                     take_low,
   input  logic                     release_en,
   input  ifu_aln_pkg::fetch_word_t wr_data,
   input  ifu_aln_pkg::pc_t         wr_pc,
   input  ifu_aln_pkg::hw_mask_t    wr_hw_val,
   input  ifu_aln_pkg::hw_mask_t    wr_fault,
   output ifu_aln_pkg::fetch_word_t data,
   output ifu_aln_pkg::pc_t         pc,
   output ifu_aln_pkg::hw_mask_t    hw_val,
   output ifu_aln_pkg::hw_mask_t    fault,
   output logic                     off
);

   // entry state: halfword valids and the consumed-low marker
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hw_val <= '0;
         off    <= 1'b0;
      end else if (flush) begin
         hw_val <= '0;
         off    <= 1'b0;
      end else if (wr_en) begin
         hw_val <= wr_hw_val;
         off    <= 1'b0;          // fresh packet starts at halfword 0
      end else begin
         if (release_en) begin
            hw_val <= '0;         // fully consumed
         end
         if (take_low) begin
            off <= 1'b1;
         end
      end
   end

   // packet payload, only meaningful while hw_val is nonzero
   always_ff @(posedge clk) begin
      if (wr_en) begin
         data  <= wr_data;
         pc    <= wr_pc;
         fault <= wr_fault;
      end
   end

endmodule

/* fetch_buf_wr_ctl.sv */
// Write pointer for the fetch buffer ring.
// Fetch owns the credit count, so a fetch_valid always lands in a free
// entry; there is no full check here.

`timescale 1ns/1ps

module fetch_buf_wr_ctl #(
   parameter int NUM_ENTRIES = 3
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flush,
   input  logic                   fetch_valid,
   output logic [NUM_ENTRIES-1:0] wr_en
);

   localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] wr_ptr_inc;

   // wrap at the last entry, ring size need not be a power of two
   assign wr_ptr_inc = (wr_ptr == PTR_W'(NUM_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
      end else if (fetch_valid) begin
         wr_ptr <= wr_ptr_inc;
      end
   end

   // one-hot write enable
   always_comb begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         wr_en[i] = fetch_valid & (wr_ptr == PTR_W'(i));
      end
   end

endmodule

/* instr_align.sv */
// Aligner core: picks the next instruction from the head entry and the
// one after it, then consumes halfwords on a take.
// The entry after the head is assumed to continue the head's PC stream.
// A 16-bit instruction is presented zero-extended, no decompression.

`timescale 1ns/1ps

module instr_align #(
   parameter int NUM_ENTRIES = 3
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     i0_take,
   input  ifu_aln_pkg::fetch_word_t ent_data [NUM_ENTRIES],
   input  ifu_aln_pkg::pc_t         ent_pc [NUM_ENTRIES],
   input  ifu_aln_pkg::hw_mask_t    ent_hw_val [NUM_ENTRIES],
   input  ifu_aln_pkg::hw_mask_t    ent_fault [NUM_ENTRIES],
   input  logic [NUM_ENTRIES-1:0]   ent_off,
   output logic [NUM_ENTRIES-1:0]   ent_take_low,
   output logic [NUM_ENTRIES-1:0]   ent_release,
   output ifu_aln_pkg::credit_t     credit_return,
   output logic                     i0_valid,
   output logic                     i0_pc4,
   output logic                     i0_fault,
   output logic                     i0_fault_second,
   output ifu_aln_pkg::fetch_word_t i0_instr,
   output ifu_aln_pkg::pc_t         i0_pc
);

   localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

   function automatic logic [PTR_W-1:0] inc_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(NUM_ENTRIES - 1)) ? '0 : p + 1'b1;
   endfunction

   logic [PTR_W-1:0]         rd_ptr;
   logic [PTR_W-1:0]         nx_ptr;
   logic [PTR_W-1:0]         nx2_ptr;

   ifu_aln_pkg::fetch_word_t h_data, n_data;
   ifu_aln_pkg::hw_mask_t    h_val, n_val;
   ifu_aln_pkg::hw_mask_t    h_fault, n_fault;
   logic                     h_off;

   ifu_aln_pkg::hw_t         first_hw, second_hw;
   logic                     two_left;          // head still holds both halfwords
   logic                     second_val;
   logic                     first_flt, second_flt;

   logic                     take;
   logic                     rel_head, rel_next;
   logic                     low_head, low_next;
   logic                     span;              // 4B instr reaching into next entry

   assign nx_ptr  = inc_ptr(rd_ptr);
   assign nx2_ptr = inc_ptr(nx_ptr);

   // ******************************
   // head and next entry select
   // ******************************

   assign h_data  = ent_data[rd_ptr];
   assign h_val   = ent_hw_val[rd_ptr];
   assign h_fault = ent_fault[rd_ptr];
   assign h_off   = ent_off[rd_ptr];

   assign n_data  = ent_data[nx_ptr];
   assign n_val   = ent_hw_val[nx_ptr];
   assign n_fault = ent_fault[nx_ptr];

   assign two_left = (h_val == 2'b11) & ~h_off;

   // ******************************
   // alignment
   // ******************************

   assign first_hw   = h_off ? h_data[31:16] : h_data[15:0];
   assign first_flt  = h_off ? h_fault[1] : h_fault[0];

   // second halfword comes from the head or the next entry's low half
   assign second_hw  = two_left ? h_data[31:16] : n_data[15:0];
   assign second_val = two_left | n_val[0];
   assign second_flt = two_left ? h_fault[1] : n_fault[0];

   assign i0_pc4   = (first_hw[1:0] == 2'b11);
   assign i0_valid = h_val[0] & (~i0_pc4 | second_val);
   assign i0_instr = i0_pc4 ? {second_hw, first_hw} : {16'h0000, first_hw};
   assign i0_pc    = ent_pc[rd_ptr] + ifu_aln_pkg::pc_t'(h_off);

   assign i0_fault        = first_flt | (i0_pc4 & second_flt);
   assign i0_fault_second = i0_pc4 & ~first_flt & second_flt;

   // ******************************
   // consume and credits
   // ******************************

   assign take = i0_valid & i0_take & ~flush;
   assign span = i0_pc4 & ~two_left;

   assign low_head = take & ~i0_pc4 & two_left;       // 2B out of a full head
   assign rel_head = take & (i0_pc4 | ~two_left);
   assign low_next = take & span & n_val[1];
   assign rel_next = take & span & ~n_val[1];         // next held a single halfword

   // rel_next implies rel_head
   assign credit_return = {rel_next, rel_head & ~rel_next};

   always_comb begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         ent_take_low[i] = (low_head & (rd_ptr == PTR_W'(i))) |
                           (low_next & (nx_ptr == PTR_W'(i)));
         ent_release[i]  = (rel_head & (rd_ptr == PTR_W'(i))) |
                           (rel_next & (nx_ptr == PTR_W'(i)));
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (flush) begin
         rd_ptr <= '0;
      end else if (rel_next) begin
         rd_ptr <= nx2_ptr;        // two entries emptied
      end else if (rel_head) begin
         rd_ptr <= nx_ptr;
      end
   end

endmodule

/* ifu_aligner.sv */
// Instruction aligner top: fetch packets into a ring of entries, one
// aligned instruction per cycle toward decode.
// Fetch must start with NUM_ENTRIES credits and only send with a credit;
// after a flush it resets its own count. NUM_ENTRIES must be 2 or more.

`timescale 1ns/1ps

module ifu_aligner #(
   parameter int NUM_ENTRIES = 3
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     fetch_valid,
   input  logic                     i0_take,
   input  ifu_aln_pkg::fetch_word_t fetch_data,
   input  ifu_aln_pkg::pc_t         fetch_pc,
   input  ifu_aln_pkg::hw_mask_t    fetch_hw_val,
   input  ifu_aln_pkg::hw_mask_t    fetch_fault,
   output ifu_aln_pkg::credit_t     credit_return,
   output logic                     i0_valid,
   output logic                     i0_pc4,
   output logic                     i0_fault,
   output logic                     i0_fault_second,
   output ifu_aln_pkg::fetch_word_t i0_instr,
   output ifu_aln_pkg::pc_t         i0_pc
);

   logic [NUM_ENTRIES-1:0]   wr_en;
   logic [NUM_ENTRIES-1:0]   ent_take_low;
   logic [NUM_ENTRIES-1:0]   ent_release;
   logic [NUM_ENTRIES-1:0]   ent_off;
   ifu_aln_pkg::fetch_word_t ent_data [NUM_ENTRIES];
   ifu_aln_pkg::pc_t         ent_pc [NUM_ENTRIES];
   ifu_aln_pkg::hw_mask_t    ent_hw_val [NUM_ENTRIES];
   ifu_aln_pkg::hw_mask_t    ent_fault [NUM_ENTRIES];

   fetch_buf_wr_ctl #(
      .NUM_ENTRIES (NUM_ENTRIES)
   ) i_wr_ctl (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .fetch_valid (fetch_valid),
      .wr_en       (wr_en)
   );

   // ******************************
   // entry ring
   // ******************************

   for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_ent
      fetch_buf_entry i_ent (
         .clk        (clk),
         .rst_n      (rst_n),
         .flush      (flush),
         .wr_en      (wr_en[i]),
         .take_low   (ent_take_low[i]),
         .release_en (ent_release[i]),
         .wr_data    (fetch_data),
         .wr_pc      (fetch_pc),
         .wr_hw_val  (fetch_hw_val),
         .wr_fault   (fetch_fault),
         .data       (ent_data[i]),
         .pc         (ent_pc[i]),
         .hw_val     (ent_hw_val[i]),
         .fault      (ent_fault[i]),
         .off        (ent_off[i])
      );
   end

   instr_align #(
      .NUM_ENTRIES (NUM_ENTRIES)
   ) i_align (
      .clk             (clk),
      .rst_n           (rst_n),
      .flush           (flush),
      .i0_take         (i0_take),
      .ent_data        (ent_data),
      .ent_pc          (ent_pc),
      .ent_hw_val      (ent_hw_val),
      .ent_fault       (ent_fault),
      .ent_off         (ent_off),
      .ent_take_low    (ent_take_low),
      .ent_release     (ent_release),
      .credit_return   (credit_return),
      .i0_valid        (i0_valid),
      .i0_pc4          (i0_pc4),
      .i0_fault        (i0_fault),
      .i0_fault_second (i0_fault_second),
      .i0_instr        (i0_instr),
      .i0_pc           (i0_pc)
   );

endmodule

/* tb_aln_vectors.svh */
// Stimulus table included in the body of the aligner testbench.
// Each row is one test with a packet list, a take pattern and an optional flush point.
// Packets of one stream must continue each other's PC as fetch would deliver them.
`ifndef TB_ALN_VECTORS_SVH
`define TB_ALN_VECTORS_SVH

localparam int N_VEC   = 6;
localparam int MAX_PKT = 6;

string                    vec_name  [N_VEC];
int                       vec_npkt  [N_VEC];
int                       vec_gap   [N_VEC];   // max random idle cycles between takes
int                       vec_hold  [N_VEC];   // take held low this long at the start
int                       vec_flush [N_VEC];   // stale packets ahead of a flush or -1
ifu_aln_pkg::fetch_word_t pkt_data  [N_VEC][MAX_PKT];
ifu_aln_pkg::pc_t         pkt_pc    [N_VEC][MAX_PKT];
ifu_aln_pkg::hw_mask_t    pkt_hv    [N_VEC][MAX_PKT];
ifu_aln_pkg::hw_mask_t    pkt_flt   [N_VEC][MAX_PKT];

task automatic set_row(input int r, input string name, input int gap, input int hold,
                       input int flush_pkts);
   vec_name[r]  = name;
   vec_npkt[r]  = 0;
   vec_gap[r]   = gap;
   vec_hold[r]  = hold;
   vec_flush[r] = flush_pkts;
endtask

task automatic add_pkt(input int r, input ifu_aln_pkg::fetch_word_t d, input ifu_aln_pkg::pc_t pc,
                       input ifu_aln_pkg::hw_mask_t hv, input ifu_aln_pkg::hw_mask_t flt);
   int n;
   n = vec_npkt[r];
   pkt_data[r][n] = d;
   pkt_pc[r][n]   = pc;
   pkt_hv[r][n]   = hv;
   pkt_flt[r][n]  = flt;
   vec_npkt[r]    = n + 1;
endtask

task automatic fill_table();
   set_row(0, "stream32", 0, 0, -1);
   add_pkt(0, 32'h0001_0013, 31'h100, 2'b11, 2'b00);
   add_pkt(0, 32'h0020_8093, 31'h102, 2'b11, 2'b00);
   add_pkt(0, 32'h0031_0113, 31'h104, 2'b11, 2'b00);
   add_pkt(0, 32'h0041_8193, 31'h106, 2'b11, 2'b00);
   add_pkt(0, 32'h0052_0213, 31'h108, 2'b11, 2'b00);
   set_row(1, "mixed", 3, 0, -1);
   add_pkt(1, 32'h0513_4501, 31'h200, 2'b11, 2'b00);  // 32b starts in the high half
   add_pkt(1, 32'h8082_1234, 31'h202, 2'b11, 2'b00);
   add_pkt(1, 32'h0062_00b3, 31'h204, 2'b11, 2'b00);
   add_pkt(1, 32'h0793_4611, 31'h206, 2'b11, 2'b00);  // trailing 32b never completes
   set_row(2, "backpressure", 1, 8, -1);
   add_pkt(2, 32'h4502_4501, 31'h300, 2'b11, 2'b00);
   add_pkt(2, 32'h0393_4503, 31'h302, 2'b11, 2'b00);
   add_pkt(2, 32'h4504_5678, 31'h304, 2'b11, 2'b00);
   add_pkt(2, 32'h0a00_0413, 31'h306, 2'b11, 2'b00);
   add_pkt(2, 32'h4506_4505, 31'h308, 2'b11, 2'b00);
   set_row(3, "faults", 0, 0, -1);
   add_pkt(3, 32'h0613_4505, 31'h400, 2'b11, 2'b01);
   add_pkt(3, 32'h4681_0001, 31'h402, 2'b11, 2'b01);  // second half of straddling 32b
   add_pkt(3, 32'h0001_0713, 31'h404, 2'b11, 2'b01);
   add_pkt(3, 32'h0002_0793, 31'h406, 2'b11, 2'b10);
   set_row(4, "partial", 2, 0, -1);
   add_pkt(4, 32'hdead_0813, 31'h500, 2'b01, 2'b00);  // high half is not valid
   add_pkt(4, 32'hbeef_1111, 31'h501, 2'b01, 2'b00);
   add_pkt(4, 32'h0793_4711, 31'h502, 2'b11, 2'b00);
   add_pkt(4, 32'h0000_2222, 31'h504, 2'b01, 2'b00);
   add_pkt(4, 32'h4802_4801, 31'h505, 2'b11, 2'b00);
   set_row(5, "flush", 0, 0, 2);
   add_pkt(5, 32'h4901_0893, 31'h600, 2'b11, 2'b00);  // stale 32b that would free its entry
   add_pkt(5, 32'h4902_0033, 31'h602, 2'b11, 2'b00);
   add_pkt(5, 32'h4a02_4a01, 31'h700, 2'b11, 2'b00);
   add_pkt(5, 32'h0a93_4a03, 31'h702, 2'b11, 2'b00);
   add_pkt(5, 32'h4a04_1357, 31'h704, 2'b11, 2'b00);
endtask

`endif

/* tb_ifu_aligner.sv */
// Testbench for the instruction aligner with a credit-counting fetch model.
// Expected instructions are parsed from the table's packets in PC order.
// Inputs change 2 ns after the rising edge and outputs are sampled at the falling edge.

`timescale 1ns/1ps

module tb_ifu_aligner;

   localparam int NUM_ENTRIES = 3;
   localparam int TIMEOUT     = 300;            // cycles per wait loop

   logic                     clk = 1'b0;
   logic                     rst_n, flush, fetch_valid, i0_take;
   ifu_aln_pkg::fetch_word_t fetch_data;
   ifu_aln_pkg::pc_t         fetch_pc;
   ifu_aln_pkg::hw_mask_t    fetch_hw_val, fetch_fault;
   ifu_aln_pkg::credit_t     credit_return;
   logic                     i0_valid, i0_pc4, i0_fault, i0_fault_second;
   ifu_aln_pkg::fetch_word_t i0_instr;
   ifu_aln_pkg::pc_t         i0_pc;

   logic [31:0] rng_state = 32'd68;
   logic [65:0] exp_q [$];                     // {pc4, fault, fault2, pc, instr}
   int          errors    = 0;
   bit          timed_out = 1'b0;

   `include "tb_aln_vectors.svh"

   ifu_aligner #(.NUM_ENTRIES(NUM_ENTRIES)) i_ifu_aligner (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   function automatic string show(input logic [65:0] v);
      return $sformatf("pc %h instr %h pc4/flt/flt2 %b", v[62:32], v[31:0], v[65:63]);
   endfunction

   // ******************************
   // reference model
   // ******************************

   task automatic build_expected(input int r, input int p0, output int full);
      ifu_aln_pkg::hw_t hw_q [$];
      ifu_aln_pkg::pc_t pc_q [$];
      logic             flt_q [$];
      int               pkt_q [$];
      int               i;
      exp_q.delete();
      for (int p = p0; p < vec_npkt[r]; p++) begin
         for (int j = 0; j < ifu_aln_pkg::HW_PER_FETCH; j++) begin
            if (pkt_hv[r][p][j]) begin
               hw_q.push_back(pkt_data[r][p][16*j +: 16]);
               pc_q.push_back(pkt_pc[r][p] + j);
               flt_q.push_back(pkt_flt[r][p][j]);
               pkt_q.push_back(p);
            end
         end
      end
      i = 0;
      while (i < hw_q.size()) begin
         if (hw_q[i][1:0] == 2'b11) begin
            if (i + 1 >= hw_q.size()) begin
               break;                            // 32b with no second half yet
            end
            exp_q.push_back({1'b1, flt_q[i] | flt_q[i+1], ~flt_q[i] & flt_q[i+1],
                             pc_q[i], hw_q[i+1], hw_q[i]});
            i += 2;
         end else begin
            exp_q.push_back({1'b0, flt_q[i], 1'b0, pc_q[i], 16'h0000, hw_q[i]});
            i += 1;
         end
      end
      // packets whose halfwords were all used
      full = (i == hw_q.size()) ? vec_npkt[r] - p0 : pkt_q[i] - p0;
   endtask

   // ******************************
   // drivers
   // ******************************

   task automatic drive_fetch(input bit en, input int r, input int p);
      fetch_valid = en;
      if (en) begin
         fetch_data   = pkt_data[r][p];
         fetch_pc     = pkt_pc[r][p];
         fetch_hw_val = pkt_hv[r][p];
         fetch_fault  = pkt_flt[r][p];
      end
   endtask

   task automatic check_timeout(input string name, input int cyc, input string what);
      assert (cyc < TIMEOUT) else begin
         $display("%s: stalled for %0d cycles while %s", name, cyc, what);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   // take is held high so the flush has to mask the credit return
   task automatic flush_ring(input string name);
      @(posedge clk);
      #2;
      drive_fetch(1'b0, 0, 0);
      i0_take = 1'b1;
      flush   = 1'b1;
      @(negedge clk);
      assert (credit_return == 0) else begin
         $display("Mismatch %s flush credits: expected 0, actual %0d", name, credit_return);
         errors++;
      end
      @(posedge clk);
      #2;
      flush   = 1'b0;
      i0_take = 1'b0;
      @(negedge clk);
      assert (!i0_valid) else begin
         $display("Mismatch %s i0_valid after flush: expected 0, actual 1", name);
         errors++;
      end
   endtask

   task automatic run_test(input int r);
      int          p0, sent, k, cyc, gap_left, hold_left, credits, cred_sum, full_pkts;
      int          exp_sent;
      logic [65:0] act, snap;
      bit          snap_ok, in_hold;
      p0 = 0;
      cyc = 0;
      sent = 0;
      if (vec_flush[r] >= 0) begin
         // stale stream flushed while its first instruction is presented
         while ((sent < vec_flush[r] || !i0_valid) && !timed_out) begin
            @(posedge clk);
            #2;
            drive_fetch(sent < vec_flush[r], r, sent);
            @(negedge clk);
            if (fetch_valid) begin
               sent++;
            end
            cyc++;
            check_timeout(vec_name[r], cyc, "waiting for the stale stream");
         end
         flush_ring(vec_name[r]);
         p0 = vec_flush[r];
      end
      build_expected(r, p0, full_pkts);
      sent      = p0;
      k         = 0;
      cyc       = 0;
      gap_left  = 0;
      hold_left = vec_hold[r];
      credits   = NUM_ENTRIES;
      cred_sum  = 0;
      snap_ok   = 1'b0;
      while (k < exp_q.size() && !timed_out) begin
         @(posedge clk);
         #2;
         drive_fetch(credits > 0 && sent < vec_npkt[r], r, sent);
         in_hold = (hold_left > 0);
         i0_take = !in_hold && gap_left == 0;
         if (in_hold) begin
            hold_left--;
         end else if (gap_left > 0) begin
            gap_left--;
         end
         @(negedge clk);
         credits  = credits + int'(credit_return) - int'(fetch_valid);
         cred_sum = cred_sum + int'(credit_return);
         if (fetch_valid) begin
            sent++;
         end
         act = {i0_pc4, i0_fault, i0_fault_second, i0_pc, i0_instr};
         if (in_hold) begin
            assert (credit_return == 0) else begin
               $display("Mismatch %s credits under back-pressure: expected 0, actual %0d",
                        vec_name[r], credit_return);
               errors++;
            end
            if (snap_ok) begin
               assert (act == snap) else begin
                  $display("Mismatch %s held output: expected %s, actual %s",
                           vec_name[r], show(snap), show(act));
                  errors++;
               end
            end else if (i0_valid) begin
               snap    = act;
               snap_ok = 1'b1;
            end
            if (hold_left == 0) begin
               exp_sent = (vec_npkt[r] < NUM_ENTRIES) ? vec_npkt[r] : NUM_ENTRIES;
               assert (sent - p0 == exp_sent) else begin
                  $display("Mismatch %s packets under back-pressure: expected %0d, actual %0d",
                           vec_name[r], exp_sent, sent - p0);
                  errors++;
               end
            end
         end
         if (i0_valid && i0_take) begin
            assert (act == exp_q[k]) else begin
               $display("Mismatch %s instr %0d: expected %s, actual %s",
                        vec_name[r], k, show(exp_q[k]), show(act));
               errors++;
            end
            k++;
            gap_left = next_rand() % (vec_gap[r] + 1);
         end
         cyc++;
         check_timeout(vec_name[r], cyc, "waiting for instructions");
      end
      if (!timed_out) begin
         assert (cred_sum == full_pkts) else begin
            $display("Mismatch %s credits returned: expected %0d, actual %0d",
                     vec_name[r], full_pkts, cred_sum);
            errors++;
         end
         flush_ring(vec_name[r]);               // clears any leftover halfword
      end
   endtask

   // ******************************
   // main sequence
   // ******************************

   initial begin
      int n_ok;
      int n_bad;
      int err0;
      n_ok  = 0;
      n_bad = 0;
      rst_n = 1'b0;
      flush = 1'b0;
      i0_take = 1'b0;
      fetch_valid = 1'b0;
      fetch_data = '0;
      fetch_pc = '0;
      fetch_hw_val = '0;
      fetch_fault = '0;
      fill_table();
      repeat (16) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      assert (!i0_valid && credit_return == 0) else begin
         $display("Mismatch reset idle: expected valid 0 credits 0, actual valid %b credits %0d",
                  i0_valid, credit_return);
         errors++;
      end
      for (int r = 0; r < N_VEC && !timed_out; r++) begin
         err0 = errors;
         run_test(r);
         if (errors == err0) begin
            $display("test %-13s ok", vec_name[r]);
            n_ok++;
         end else begin
            $display("test %-13s %0d errors", vec_name[r], errors - err0);
            n_bad++;
         end
      end
      $display("tests ok: %0d, tests with errors: %0d, total errors: %0d", n_ok, n_bad, errors);
      if (errors == 0 && !timed_out) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+.
ifu_aln_pkg.sv
fetch_buf_entry.sv
fetch_buf_wr_ctl.sv
instr_align.sv
ifu_aligner.sv
tb_ifu_aligner.sv

/* Bender.yml */
package:
  name: ifu_aligner

sources:
  - ifu_aln_pkg.sv
  - fetch_buf_entry.sv
  - fetch_buf_wr_ctl.sv
  - instr_align.sv
  - ifu_aligner.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ifu_aligner.sv
